//--- include/rv_core_settings.svh
// ****************************
// rv core settings
// widths, register count and reset address
// ****************************
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5

// first fetch address
`define RESET_PC    32'h8000_0000

`endif

//--- source/rv_core_pkg.sv
// ****************************
// rv core package
// word types, enums and structs shared by the units
// ****************************
`include "rv_core_settings.svh"

package rv_core_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [3:0] {
        ALU_REG, ALU_IMM, LUI, AUIPC, JAL, JALR,
        BRANCH, LOAD, STORE, EBREAK, ILLEGAL
    } inst_kind_t;

    typedef struct packed {
        inst_kind_t kind;
        alu_op_t    alu_op;
        logic [2:0] funct3;   // branch condition
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
    } decoded_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } reg_write_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  write;   // 0 = word load
    } dmem_req_t;

    typedef enum logic [1:0] {S_FETCH, S_EXECUTE, S_MEMORY, S_HALT} seq_state_t;

endpackage

//--- source/fetch_unit.sv
// ****************************
// fetch unit
// pc, instruction register, imem handshake
// ****************************
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module fetch_unit import rv_core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  fetch_en,
    input  logic  pc_update,
    input  word_t next_pc,
    output word_t pc,
    output word_t inst,
    output logic  fetch_done,
    output logic  imem_req,
    output word_t imem_addr,
    input  logic  imem_ack,
    input  word_t imem_rdata
);

    logic release_wait;  // ack seen, waiting for it to drop
    logic start;

    // no restart while the done pulse is still out
    assign start     = fetch_en && !imem_req && !release_wait && !fetch_done;
    assign imem_addr = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (pc_update) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            imem_req     <= 1'b0;
            release_wait <= 1'b0;
            fetch_done   <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            if (start) begin
                imem_req <= 1'b1;
            end else if (imem_req && imem_ack) begin
                imem_req     <= 1'b0;
                release_wait <= 1'b1;
            end else if (release_wait && !imem_ack) begin
                release_wait <= 1'b0;
                fetch_done   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_req && imem_ack) inst <= imem_rdata;  // data valid with ack
    end

endmodule

//--- source/decode_unit.sv
// ****************************
// decode unit
// instruction fields, class and immediate
// ****************************
`timescale 1ns/100ps

module decode_unit import rv_core_pkg::*; (
    input  word_t    inst,
    output decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       funct7_ok;  // all zero, or bit 5 alone
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign funct7    = inst[31:25];
    assign funct7_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec        = '0;
        dec.funct3 = funct3;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.imm    = imm_i;
        dec.kind   = ILLEGAL;

        case (funct3)
            3'b000:  dec.alu_op = (opcode == 7'b0110011 && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  dec.alu_op = ALU_SLL;
            3'b010:  dec.alu_op = ALU_SLT;
            3'b011:  dec.alu_op = ALU_SLTU;
            3'b100:  dec.alu_op = ALU_XOR;
            3'b101:  dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  dec.alu_op = ALU_OR;
            default: dec.alu_op = ALU_AND;
        endcase

        case (opcode)
            7'b0110011: begin
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
                    dec.kind = ALU_REG;
            end
            7'b0010011: begin
                if (funct3 == 3'b001) begin
                    if (funct7 == 7'b0000000) dec.kind = ALU_IMM;
                end else if (funct3 == 3'b101) begin
                    if (funct7_ok) dec.kind = ALU_IMM;  // srli / srai
                end else begin
                    dec.kind = ALU_IMM;
                end
            end
            7'b0110111: begin
                dec.kind = LUI;
                dec.imm  = imm_u;
            end
            7'b0010111: begin
                dec.kind = AUIPC;
                dec.imm  = imm_u;
            end
            7'b1101111: begin
                dec.kind = JAL;
                dec.imm  = imm_j;
            end
            7'b1100111: if (funct3 == 3'b000) dec.kind = JALR;
            7'b1100011: begin
                if (funct3 != 3'b010 && funct3 != 3'b011) dec.kind = BRANCH;
                dec.imm = imm_b;
            end
            7'b0000011: if (funct3 == 3'b010) dec.kind = LOAD;  // lw only
            7'b0100011: begin
                if (funct3 == 3'b010) dec.kind = STORE;  // sw only
                dec.imm = imm_s;
            end
            7'b1110011: if (inst == 32'h0010_0073) dec.kind = EBREAK;
            default: dec.kind = ILLEGAL;
        endcase
    end

endmodule

//--- source/reg_file.sv
// ****************************
// register file
// two async reads, one write
// ****************************
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module reg_file import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  reg_addr_t  rs1,
    input  reg_addr_t  rs2,
    input  reg_write_t reg_write,
    output word_t      rdata1,
    output word_t      rdata2
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write.we) begin
            regs[reg_write.rd] <= reg_write.data;
        end
    end

    // x0 always reads zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- source/execute_unit.sv
// ****************************
// execute unit
// alu, branch compare, next pc
// ****************************
`timescale 1ns/100ps

module execute_unit import rv_core_pkg::*; (
    input  decoded_t  dec,
    input  word_t     pc,
    input  word_t     rdata1,
    input  word_t     rdata2,
    output word_t     result,
    output word_t     next_pc,
    output dmem_req_t mem_cmd
);

    word_t   op_a, op_b, alu_out;
    word_t   pc_plus4, pc_target;
    alu_op_t op;
    logic    taken;

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + dec.imm;  // jal and branch

    // non-alu kinds only need an add
    assign op = (dec.kind == ALU_REG || dec.kind == ALU_IMM) ? dec.alu_op : ALU_ADD;

    always_comb begin
        op_a = rdata1;
        op_b = dec.imm;
        case (dec.kind)
            ALU_REG: op_b = rdata2;
            LUI:     op_a = '0;
            AUIPC:   op_a = pc;
            default: ;
        endcase
    end

    always_comb begin
        case (op)
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << op_b[4:0];
            ALU_SLT:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_out = {31'b0, op_a < op_b};
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = op_a >> op_b[4:0];
            ALU_SRA:  alu_out = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            default:  alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rdata1 == rdata2);
            3'b001:  taken = (rdata1 != rdata2);
            3'b100:  taken = $signed(rdata1) < $signed(rdata2);
            3'b101:  taken = $signed(rdata1) >= $signed(rdata2);
            3'b110:  taken = rdata1 < rdata2;
            default: taken = rdata1 >= rdata2;  // bgeu
        endcase
    end

    always_comb begin
        next_pc = pc_plus4;
        case (dec.kind)
            JAL:     next_pc = pc_target;
            JALR:    next_pc = {alu_out[31:1], 1'b0};
            BRANCH:  if (taken) next_pc = pc_target;
            default: ;
        endcase
    end

    assign result = (dec.kind == JAL || dec.kind == JALR) ? pc_plus4 : alu_out;

    assign mem_cmd.addr  = alu_out;  // rs1 + imm
    assign mem_cmd.wdata = rdata2;
    assign mem_cmd.write = (dec.kind == STORE);

endmodule

//--- source/load_store_unit.sv
// ****************************
// load/store unit
// dmem handshake for word access
// ****************************
`timescale 1ns/100ps

module load_store_unit import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      mem_en,
    input  dmem_req_t mem_cmd,
    output logic      mem_done,
    output word_t     load_data,
    output logic      dmem_req,
    output dmem_req_t dmem_cmd,
    input  logic      dmem_ack,
    input  word_t     dmem_rdata
);

    logic release_wait;
    logic start;

    assign start = mem_en && !dmem_req && !release_wait && !mem_done;

    // command held stable for the whole transfer
    always_ff @(posedge clk) begin
        if (start) dmem_cmd <= mem_cmd;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dmem_req     <= 1'b0;
            release_wait <= 1'b0;
            mem_done     <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (start) begin
                dmem_req <= 1'b1;
            end else if (dmem_req && dmem_ack) begin
                dmem_req     <= 1'b0;
                release_wait <= 1'b1;
            end else if (release_wait && !dmem_ack) begin
                release_wait <= 1'b0;
                mem_done     <= 1'b1;  // ack low again
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_req && dmem_ack && !dmem_cmd.write) begin
            load_data <= dmem_rdata;
        end
    end

endmodule

//--- source/core_sequencer.sv
// ****************************
// core sequencer
// fetch/execute/memory FSM, retire, halt
// ****************************
`timescale 1ns/100ps

module core_sequencer import rv_core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  decoded_t   dec,
    input  word_t      result,
    input  word_t      load_data,
    input  logic       fetch_done,
    input  logic       mem_done,
    output logic       fetch_en,
    output logic       mem_en,
    output logic       pc_update,
    output reg_write_t reg_write,
    output logic       halted,
    output logic       error
);

    seq_state_t state;
    logic       is_mem, writes_rd;

    assign is_mem    = (dec.kind == LOAD) || (dec.kind == STORE);
    assign writes_rd = !(dec.kind inside {BRANCH, STORE, EBREAK, ILLEGAL});

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_FETCH;
            error <= 1'b0;
        end else begin
            case (state)
                S_FETCH:   if (fetch_done) state <= S_EXECUTE;
                S_EXECUTE: begin
                    if (dec.kind == EBREAK || dec.kind == ILLEGAL) state <= S_HALT;
                    else if (is_mem) state <= S_MEMORY;
                    else state <= S_FETCH;
                    if (dec.kind == ILLEGAL) error <= 1'b1;
                end
                S_MEMORY:  if (mem_done) state <= S_FETCH;
                default:   state <= S_HALT;  // stays until reset
            endcase
        end
    end

    assign fetch_en = (state == S_FETCH);
    assign mem_en   = (state == S_MEMORY);
    assign halted   = (state == S_HALT);

    // retire on the edge leaving execute or memory
    assign pc_update = (state == S_EXECUTE && writes_rd && !is_mem) ||
                       (state == S_EXECUTE && dec.kind == BRANCH) ||
                       (state == S_MEMORY && mem_done);

    assign reg_write.we   = pc_update && writes_rd;
    assign reg_write.rd   = dec.rd;
    assign reg_write.data = (dec.kind == LOAD) ? load_data : result;

endmodule

//--- source/rv_core_top.sv
// ****************************
// rv core top
// multi-cycle RV32I core, units wired together
// ****************************
`timescale 1ns/100ps

module rv_core_top import rv_core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    output logic      imem_req,
    output word_t     imem_addr,
    input  logic      imem_ack,
    input  word_t     imem_rdata,
    output logic      dmem_req,
    output dmem_req_t dmem_cmd,
    input  logic      dmem_ack,
    input  word_t     dmem_rdata,
    output logic      halted,
    output logic      error
);

    word_t      pc, inst, next_pc, result, load_data, rdata1, rdata2;
    decoded_t   dec;
    dmem_req_t  mem_cmd;
    reg_write_t reg_write;
    logic       fetch_en, fetch_done, mem_en, mem_done, pc_update;

    fetch_unit u_fetch_unit (
        .clk(clk), .reset(reset), .fetch_en(fetch_en), .pc_update(pc_update),
        .next_pc(next_pc), .pc(pc), .inst(inst), .fetch_done(fetch_done),
        .imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack),
        .imem_rdata(imem_rdata)
    );

    decode_unit u_decode_unit (.inst(inst), .dec(dec));

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .rs1(dec.rs1), .rs2(dec.rs2),
        .reg_write(reg_write), .rdata1(rdata1), .rdata2(rdata2)
    );

    execute_unit u_execute_unit (
        .dec(dec), .pc(pc), .rdata1(rdata1), .rdata2(rdata2),
        .result(result), .next_pc(next_pc), .mem_cmd(mem_cmd)
    );

    load_store_unit u_load_store_unit (
        .clk(clk), .reset(reset), .mem_en(mem_en), .mem_cmd(mem_cmd),
        .mem_done(mem_done), .load_data(load_data), .dmem_req(dmem_req),
        .dmem_cmd(dmem_cmd), .dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata)
    );

    core_sequencer u_core_sequencer (
        .clk(clk), .reset(reset), .dec(dec), .result(result), .load_data(load_data),
        .fetch_done(fetch_done), .mem_done(mem_done), .fetch_en(fetch_en),
        .mem_en(mem_en), .pc_update(pc_update), .reg_write(reg_write),
        .halted(halted), .error(error)
    );

endmodule

//--- tests/rv_core_checker.sv
// ****************************
// rv core checker
// compares data stores and halt status
// ****************************
`timescale 1ns/100ps

module rv_core_checker import rv_core_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      dmem_req,
    input logic      dmem_ack,
    input dmem_req_t dmem_cmd,
    input logic      halted,
    input logic      error
);

    word_t exp_addr [$];
    word_t exp_data [$];
    logic  ack_q;
    int    test_errors;

    task automatic clear_expect();
        exp_addr.delete();
        exp_data.delete();
        test_errors = 0;
    endtask

    task automatic expect_store(input word_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // write accepted when ack rises
    always @(posedge clk) begin
        ack_q <= dmem_ack;
        if (!reset && dmem_req && dmem_ack && !ack_q && dmem_cmd.write) begin
            if (exp_addr.size() == 0) begin
                $display("extra store to address %h with data %h", dmem_cmd.addr,
                         dmem_cmd.wdata);
                test_errors++;
            end else begin
                if (dmem_cmd.addr !== exp_addr[0]) begin
                    $display("Fail dmem_cmd.addr got %h expected %h", dmem_cmd.addr,
                             exp_addr[0]);
                    test_errors++;
                end
                if (dmem_cmd.wdata !== exp_data[0]) begin
                    $display("Fail dmem_cmd.wdata got %h expected %h", dmem_cmd.wdata,
                             exp_data[0]);
                    test_errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    task automatic end_test(input logic exp_error, input logic timed_out, output logic ok);
        if (timed_out) begin
            $display("core did not halt before the timeout");
            test_errors++;
        end else if (halted !== 1'b1) begin
            $display("Fail halted got %h expected %h", halted, 1'b1);  // must stay high
            test_errors++;
        end
        if (exp_addr.size() != 0) begin
            $display("%0d expected stores never happened", exp_addr.size());
            test_errors++;
        end
        if (!timed_out && error !== exp_error) begin
            $display("Fail error got %h expected %h", error, exp_error);
            test_errors++;
        end
        ok = (test_errors == 0);
    endtask

endmodule

//--- tests/tb_rv_core.sv
// ****************************
// rv core testbench
// memory models with random ack delay, program table
// ****************************
`timescale 1ns/100ps
`include "rv_core_settings.svh"

module tb_rv_core import rv_core_pkg::*; ();

    localparam int NUM_TESTS = 8;
    localparam int PROG_LEN  = 32;
    localparam int MAX_ST    = 12;
    localparam int TIMEOUT   = 3000;

    logic      clk, reset;
    logic      imem_req, imem_ack, dmem_req, dmem_ack, halted, error;
    word_t     imem_addr, imem_rdata, dmem_rdata;
    dmem_req_t dmem_cmd;

    word_t prog [NUM_TESTS][PROG_LEN];
    word_t st_addr_tab [NUM_TESTS][MAX_ST];
    word_t st_data_tab [NUM_TESTS][MAX_ST];
    int    st_count [NUM_TESTS];
    logic  err_tab [NUM_TESTS];
    string names [NUM_TESTS];

    word_t imem [PROG_LEN];
    word_t dmem [64];
    word_t rng;
    int    i_wait, d_wait;
    int    cur_t, cur_n;
    word_t st_addr;

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        dmem_ack   = 1'b0;
        dmem_rdata = '0;
        rng        = 32'h039bfc6e;
        i_wait     = 0;
        d_wait     = 0;
    end

    always #5 clk = ~clk;

    rv_core_top u_rv_core_top (
        .clk(clk), .reset(reset), .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_ack(imem_ack), .imem_rdata(imem_rdata), .dmem_req(dmem_req),
        .dmem_cmd(dmem_cmd), .dmem_ack(dmem_ack), .dmem_rdata(dmem_rdata),
        .halted(halted), .error(error)
    );

    rv_core_checker u_rv_core_checker (
        .clk(clk), .reset(reset), .dmem_req(dmem_req), .dmem_ack(dmem_ack),
        .dmem_cmd(dmem_cmd), .halted(halted), .error(error)
    );

    function automatic word_t lcg(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        word_t off;
        off = addr - `RESET_PC;
        // outside the program or misaligned, opcode 0 decodes illegal
        if (off >= PROG_LEN * 4 || off[1:0] != 2'b00) return '0;
        return imem[off[6:2]];
    endfunction

    // both memory ports, ack delay 0..3 cycles
    always @(posedge clk) begin
        if (reset) begin
            imem_ack <= 1'b0;
            dmem_ack <= 1'b0;
        end else begin
            if (imem_req && !imem_ack) begin
                if (i_wait == 0) begin
                    imem_ack   <= 1'b1;
                    imem_rdata <= fetch_word(imem_addr);
                    rng = lcg(rng);
                    i_wait <= rng[30:29];
                end else begin
                    i_wait <= i_wait - 1;
                end
            end else if (!imem_req && imem_ack) begin
                imem_ack <= 1'b0;
            end
            if (dmem_req && !dmem_ack) begin
                if (d_wait == 0) begin
                    dmem_ack   <= 1'b1;
                    dmem_rdata <= dmem[dmem_cmd.addr[7:2]];
                    if (dmem_cmd.write) dmem[dmem_cmd.addr[7:2]] <= dmem_cmd.wdata;
                    rng = lcg(rng);
                    d_wait <= rng[30:29];
                end else begin
                    d_wait <= d_wait - 1;
                end
            end else if (!dmem_req && dmem_ack) begin
                dmem_ack <= 1'b0;
            end
        end
    end

    function automatic word_t r_type(input int f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic word_t i_type(input int imm, rs1, f3, rd, op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t s_type(input int imm, rs2, rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t b_type(input int imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t u_type(input int imm20, rd, op);
        return {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t j_type(input int imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic new_test(input string name, input logic err);
        cur_t++;
        cur_n   = 0;
        st_addr = 32'h100;
        names[cur_t]    = name;
        err_tab[cur_t]  = err;
        st_count[cur_t] = 0;
        for (int i = 0; i < PROG_LEN; i++) prog[cur_t][i] = '0;
    endtask

    task automatic emit(input word_t inst);
        prog[cur_t][cur_n] = inst;
        cur_n++;
    endtask

    task automatic expect_st(input word_t addr, input word_t data);
        st_addr_tab[cur_t][st_count[cur_t]] = addr;
        st_data_tab[cur_t][st_count[cur_t]] = data;
        st_count[cur_t]++;
    endtask

    // op writes x3, then x3 goes to the next store slot
    task automatic op_case(input word_t inst, input word_t val);
        emit(inst);
        emit(s_type(st_addr, 3, 0));
        expect_st(st_addr, val);
        st_addr += 4;
    endtask

    // marker 1 when taken, 2 when it falls through
    task automatic branch_case(input int rs1, input int rs2, input int f3, input logic taken);
        emit(i_type(1, 0, 0, 3, 7'h13));
        emit(b_type(8, rs2, rs1, f3));
        emit(i_type(2, 0, 0, 3, 7'h13));
        emit(s_type(st_addr, 3, 0));
        expect_st(st_addr, taken ? 32'd1 : 32'd2);
        st_addr += 4;
    endtask

    task automatic build_table();
        cur_t = -1;
        new_test("alu_reg", 1'b0);
        emit(i_type(-7, 0, 0, 1, 7'h13));
        emit(i_type(3, 0, 0, 2, 7'h13));
        op_case(r_type(0, 2, 1, 0, 3), 32'hffff_fffc);
        op_case(r_type(7'h20, 2, 1, 0, 3), 32'hffff_fff6);
        op_case(r_type(0, 2, 1, 1, 3), 32'hffff_ffc8);
        op_case(r_type(0, 2, 1, 2, 3), 32'h1);
        op_case(r_type(0, 2, 1, 3, 3), 32'h0);
        op_case(r_type(0, 2, 1, 4, 3), 32'hffff_fffa);
        op_case(r_type(0, 2, 1, 5, 3), 32'h1fff_ffff);
        op_case(r_type(7'h20, 2, 1, 5, 3), 32'hffff_ffff);
        op_case(r_type(0, 2, 1, 6, 3), 32'hffff_fffb);
        op_case(r_type(0, 2, 1, 7, 3), 32'h1);
        emit(32'h0010_0073);

        new_test("alu_imm", 1'b0);
        emit(i_type(-7, 0, 0, 1, 7'h13));
        op_case(i_type(5, 1, 0, 3, 7'h13), 32'hffff_fffe);
        op_case(i_type(-6, 1, 2, 3, 7'h13), 32'h1);
        op_case(i_type(5, 1, 3, 3, 7'h13), 32'h0);
        op_case(i_type(-1, 1, 4, 3, 7'h13), 32'h6);
        op_case(i_type(6, 1, 6, 3, 7'h13), 32'hffff_ffff);
        op_case(i_type(12'h0f0, 1, 7, 3, 7'h13), 32'hf0);
        op_case(i_type(4, 1, 1, 3, 7'h13), 32'hffff_ff90);
        op_case(i_type(28, 1, 5, 3, 7'h13), 32'hf);
        op_case(i_type(12'h401, 1, 5, 3, 7'h13), 32'hffff_fffc);
        emit(32'h0010_0073);

        new_test("lui_auipc", 1'b0);
        op_case(u_type(20'h12345, 3, 7'h37), 32'h1234_5000);
        op_case(u_type(1, 3, 7'h17), `RESET_PC + 32'h1008);
        emit(32'h0010_0073);

        new_test("branch_a", 1'b0);
        emit(i_type(-7, 0, 0, 1, 7'h13));
        emit(i_type(3, 0, 0, 2, 7'h13));
        branch_case(1, 2, 0, 1'b0);
        branch_case(1, 2, 1, 1'b1);
        branch_case(1, 2, 4, 1'b1);
        branch_case(1, 2, 5, 1'b0);
        branch_case(1, 2, 6, 1'b0);
        branch_case(1, 2, 7, 1'b1);
        emit(32'h0010_0073);

        new_test("branch_b", 1'b0);
        emit(i_type(-7, 0, 0, 1, 7'h13));
        emit(i_type(3, 0, 0, 2, 7'h13));
        branch_case(1, 1, 0, 1'b1);
        branch_case(1, 1, 1, 1'b0);
        branch_case(2, 1, 4, 1'b0);
        branch_case(2, 1, 5, 1'b1);
        branch_case(2, 1, 6, 1'b1);
        branch_case(2, 1, 7, 1'b0);
        emit(32'h0010_0073);

        new_test("jal_jalr", 1'b0);
        emit(j_type(12, 5));
        emit(i_type(99, 0, 0, 3, 7'h13));
        emit(s_type(12'h108, 3, 0));
        emit(s_type(12'h100, 5, 0));
        emit(u_type(0, 6, 7'h17));
        emit(i_type(17, 6, 0, 7, 7'h67));  // odd target, bit 0 dropped
        emit(i_type(99, 0, 0, 3, 7'h13));
        emit(s_type(12'h108, 3, 0));
        emit(s_type(12'h104, 7, 0));
        emit(32'h0010_0073);
        expect_st(32'h100, `RESET_PC + 32'h4);
        expect_st(32'h104, `RESET_PC + 32'h18);

        new_test("load_store", 1'b0);
        emit(u_type(20'hdeadb, 1, 7'h37));
        emit(i_type(-273, 1, 0, 1, 7'h13));
        emit(s_type(12'h100, 1, 0));
        emit(i_type(12'h100, 0, 2, 4, 7'h03));
        emit(s_type(12'h104, 4, 0));
        emit(i_type(5, 0, 0, 0, 7'h13));
        emit(s_type(12'h108, 0, 0));
        emit(32'h0010_0073);
        expect_st(32'h100, 32'hdead_aeef);
        expect_st(32'h104, 32'hdead_aeef);
        expect_st(32'h108, 32'h0);

        new_test("illegal", 1'b1);
        emit(i_type(7, 0, 0, 3, 7'h13));
        emit(s_type(12'h100, 3, 0));
        emit(i_type(12'h100, 0, 0, 4, 7'h03));  // lb is not supported
        emit(s_type(12'h104, 3, 0));
        emit(32'h0010_0073);
        expect_st(32'h100, 32'h7);
    endtask

    initial begin
        int   passed;
        int   failed;
        int   cyc;
        logic ok;
        passed = 0;
        failed = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge clk);
            reset <= 1'b1;
            for (int i = 0; i < PROG_LEN; i++) imem[i] = prog[t][i];
            for (int i = 0; i < 64; i++) dmem[i] = 32'hc3c3_0000 ^ (32'h100 + i * 4);
            u_rv_core_checker.clear_expect();
            for (int s = 0; s < st_count[t]; s++) begin
                u_rv_core_checker.expect_store(st_addr_tab[t][s], st_data_tab[t][s]);
            end
            repeat (8) @(posedge clk);
            reset <= 1'b0;
            cyc = 0;
            while (!halted && cyc < TIMEOUT) begin
                @(posedge clk);
                cyc++;
            end
            repeat (3) @(posedge clk);
            u_rv_core_checker.end_test(err_tab[t], cyc >= TIMEOUT, ok);
            if (ok) begin
                passed++;
                $display("test %0d %s: ok", t, names[t]);
            end else begin
                failed++;
                $display("test %0d %s: failed", t, names[t]);
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", NUM_TESTS, passed, failed);
        if (failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+include
source/rv_core_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/execute_unit.sv
source/load_store_unit.sv
source/core_sequencer.sv
source/rv_core_top.sv
tests/rv_core_checker.sv
tests/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/rv_core_pkg.sv
      - source/fetch_unit.sv
      - source/decode_unit.sv
      - source/reg_file.sv
      - source/execute_unit.sv
      - source/load_store_unit.sv
      - source/core_sequencer.sv
      - source/rv_core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/rv_core_checker.sv
      - tests/tb_rv_core.sv
